// File: all.f
board_pkg.sv
tick_gen.sv
inmp441_mic_i2s_receiver.sv
peak_meter.sv
display_mode_fsm.sv
seven_seg_mux.sv
top.sv
board_specific_top.sv
tb_board_top.sv

// File: board_pkg.sv
`default_nettype none

package board_pkg;

    // ------------------------------------------------------------------------
    // Board dimensions
    // ------------------------------------------------------------------------

    localparam int w_sample = 24;  // INMP441 sample width
    localparam int w_led    = 16;  // LED bar length
    localparam int w_digit  = 6;   // Six hex digits cover one full sample
    localparam int w_key    = 2;
    localparam int w_sw     = 1;

    // ------------------------------------------------------------------------
    // Shared types
    // ------------------------------------------------------------------------

    // One microphone sample plus its strobe
    typedef struct packed {
        logic signed [w_sample-1:0] data;   // Held until the next strobe
        logic                       valid;  // Single-cycle pulse
    } mic_sample_t;

    // Seven-segment drive, both fields active high
    typedef struct packed {
        logic [7:0]         abcdefgh;  // Segment a in bit 7, dp in bit 0
        logic [w_digit-1:0] digit;     // One-hot digit enable
    } seg_drive_t;

    typedef enum logic [1:0] {
        mode_sample,  // Live sample
        mode_peak,    // Held peak of last tick
        mode_freeze   // Display held
    } display_mode_e;

    typedef enum logic [1:0] {
        st_idle,   // Waiting for first left slot
        st_skip,   // One-bit I2S delay
        st_shift,  // Collecting 24 data bits
        st_pad     // Rest of the frame
    } i2s_state_e;

endpackage

`default_nettype wire

// File: board_specific_top.sv
`default_nettype none

module board_specific_top
    import board_pkg::*;
#(
    parameter int clk_mhz      = 50,
    parameter int tick_hz      = 2,
    parameter int mic_sck_half = 8,
    parameter int scan_div     = 5000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [w_key-1:0]   key_n,     // Low when pressed
    input  logic [w_sw-1:0]    sw,
    output logic [w_led-1:0]   led,
    output logic [7:0]         abcdefgh,
    output logic [w_digit-1:0] digit_n,   // Low enables a digit
    output logic               mic_sck,
    output logic               mic_ws,
    output logic               mic_lr,
    input  logic               mic_sd
);

    seg_drive_t seg;

    top #(
        .clk_mhz      (clk_mhz),
        .tick_hz      (tick_hz),
        .mic_sck_half (mic_sck_half),
        .scan_div     (scan_div)
    ) i_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .key     (~key_n),   // Bring keys to active high
        .sw      (sw),
        .led     (led),
        .seg     (seg),
        .mic_sck (mic_sck),
        .mic_ws  (mic_ws),
        .mic_sd  (mic_sd)
    );

    assign abcdefgh = seg.abcdefgh;
    assign digit_n  = ~seg.digit;
    assign mic_lr   = 1'b0;          // Mic answers in the left slot

endmodule

`default_nettype wire

// File: display_mode_fsm.sv
`default_nettype none

module display_mode_fsm
    import board_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic [w_key-1:0]    key,
    input  mic_sample_t         sample,
    input  logic [w_sample-1:0] peak,
    output logic [w_sample-1:0] display_value
);

    logic [w_key-1:0] key_s1;    // Synchronizer stage 1
    logic [w_key-1:0] key_s2;    // Synchronizer stage 2
    logic [w_key-1:0] key_q;     // For edge detect
    logic [w_key-1:0] key_rise;
    display_mode_e    mode;
    display_mode_e    mode_next;

    // ------------------------------------------------------------------------
    // Key input
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_s1 <= '0;
            key_s2 <= '0;
            key_q  <= '0;
        end else begin
            key_s1 <= key;
            key_s2 <= key_s1;
            key_q  <= key_s2;
        end
    end

    assign key_rise = key_s2 & ~key_q;

    // ------------------------------------------------------------------------
    // Mode FSM
    // ------------------------------------------------------------------------

    always_comb begin
        mode_next = mode;
        if (key_rise[1]) begin
            mode_next = mode_sample;  // Key 1 wins
        end else if (key_rise[0]) begin
            unique case (mode)
                mode_sample: mode_next = mode_peak;
                mode_peak:   mode_next = mode_freeze;
                mode_freeze: mode_next = mode_sample;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode          <= mode_sample;
            display_value <= '0;
        end else begin
            mode <= mode_next;
            unique case (mode)
                mode_sample: display_value <= sample.data;
                mode_peak:   display_value <= peak;
                mode_freeze: display_value <= display_value;  // Hold
            endcase
        end
    end

    mode_legal : assert property (@(posedge clk) disable iff (!rst_n)
        mode inside {mode_sample, mode_peak, mode_freeze});

endmodule

`default_nettype wire

// File: inmp441_mic_i2s_receiver.sv
`default_nettype none

module inmp441_mic_i2s_receiver
    import board_pkg::*;
#(
    parameter int mic_sck_half = 8  // clk cycles per sck half period
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic        sck,
    output logic        ws,
    input  logic        sd,
    output mic_sample_t sample
);

    localparam int w_half = $clog2(mic_sck_half + 1);

    logic [w_half-1:0]   half_cnt;
    logic                half_done;
    logic                sck_rise;     // sck about to go high
    logic                sck_fall;     // sck about to go low
    logic [5:0]          bit_cnt;      // sck periods in frame
    logic [5:0]          bit_next;
    logic                frame_start;  // ws falls here
    i2s_state_e          state;
    logic [4:0]          shift_cnt;
    logic [w_sample-1:0] shreg;

    // ------------------------------------------------------------------------
    // Serial clock and word select
    // ------------------------------------------------------------------------

    assign half_done   = (half_cnt == w_half'(mic_sck_half - 1));
    assign sck_rise    = half_done & ~sck;
    assign sck_fall    = half_done & sck;
    assign bit_next    = bit_cnt + 6'd1;
    assign frame_start = sck_fall & (bit_cnt == 6'd63);  // End of right slot

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            half_cnt <= '0;
            sck      <= 1'b0;
        end else if (half_done) begin
            half_cnt <= '0;
            sck      <= ~sck;
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // ws low for periods 0..31, high for 32..63
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            ws      <= 1'b0;
        end else if (sck_fall) begin
            bit_cnt <= bit_next;
            ws      <= bit_next[5];
        end
    end

    // ------------------------------------------------------------------------
    // Sample assembly
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (state == st_shift && sck_rise) begin
            shreg <= {shreg[w_sample-2:0], sd};  // MSB first
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= st_idle;
            shift_cnt <= '0;
            sample    <= '0;
        end else begin
            sample.valid <= 1'b0;  // Strobe by default
            unique case (state)
                st_idle: if (frame_start) state <= st_skip;
                st_skip: begin
                    if (sck_rise) begin  // Drop the delay bit
                        state     <= st_shift;
                        shift_cnt <= '0;
                    end
                end
                st_shift: begin
                    if (sck_rise) begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (shift_cnt == 5'(w_sample - 1)) begin  // LSB taken now
                            sample.data  <= {shreg[w_sample-2:0], sd};
                            sample.valid <= 1'b1;
                            state        <= st_pad;
                        end
                    end
                end
                st_pad: if (frame_start) state <= st_skip;  // Ignore trailing bits
            endcase
        end
    end

    // ws and sck move on the same edge
    ws_on_sck_fall : assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $fell(sck));

endmodule

`default_nettype wire

// File: peak_meter.sv
`default_nettype none

module peak_meter
    import board_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  mic_sample_t         sample,
    input  logic                slow_tick,
    input  logic                led_raw,    // Show raw sample bits on the LEDs
    output logic [w_sample-1:0] peak,
    output logic [w_led-1:0]    led
);

    logic [w_sample-1:0] mag;      // |sample|
    logic [w_sample-1:0] run_max;  // Max of current interval
    logic [w_led-1:0]    bar;

    // Absolute value, most negative code clips to full scale
    always_comb begin
        if (!sample.data[w_sample-1]) begin
            mag = sample.data;
        end else if (sample.data == {1'b1, {(w_sample - 1){1'b0}}}) begin
            mag = {1'b0, {(w_sample - 1){1'b1}}};
        end else begin
            mag = w_sample'(-sample.data);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_max <= '0;
            peak    <= '0;
        end else if (slow_tick) begin
            peak    <= run_max;
            run_max <= sample.valid ? mag : '0;  // Same-cycle sample opens new interval
        end else if (sample.valid && mag > run_max) begin
            run_max <= mag;
        end
    end

    // Thermometer, one LED per octave from 2^8
    always_comb begin
        for (int i = 0; i < w_led; i++) begin
            bar[i] = (peak >= (w_sample'(1) << (i + 8)));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led <= '0;
        end else begin
            led <= led_raw ? sample.data[w_sample-1 -: w_led] : bar;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board_top -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

// File: seven_seg_mux.sv
`default_nettype none

module seven_seg_mux
    import board_pkg::*;
#(
    parameter int scan_div = 5000  // clk cycles per digit
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [w_sample-1:0] value,
    output seg_drive_t          seg
);

    localparam int w_scan = $clog2(scan_div + 1);

    logic [w_scan-1:0] scan_cnt;
    logic [2:0]        digit_idx;  // 0 is the low nibble
    logic [3:0]        nibble;

    // ------------------------------------------------------------------------
    // Digit scan
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == w_scan'(scan_div - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= (digit_idx == 3'(w_digit - 1)) ? 3'd0 : digit_idx + 3'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble = value[digit_idx * 4 +: 4];

    // ------------------------------------------------------------------------
    // Hex decode, dp always off
    // ------------------------------------------------------------------------

    always_comb begin
        seg.digit = w_digit'(1) << digit_idx;
        unique case (nibble)
            4'h0: seg.abcdefgh = 8'hfc;
            4'h1: seg.abcdefgh = 8'h60;
            4'h2: seg.abcdefgh = 8'hda;
            4'h3: seg.abcdefgh = 8'hf2;
            4'h4: seg.abcdefgh = 8'h66;
            4'h5: seg.abcdefgh = 8'hb6;
            4'h6: seg.abcdefgh = 8'hbe;
            4'h7: seg.abcdefgh = 8'he0;
            4'h8: seg.abcdefgh = 8'hfe;
            4'h9: seg.abcdefgh = 8'hf6;
            4'ha: seg.abcdefgh = 8'hee;
            4'hb: seg.abcdefgh = 8'h3e;  // Lower case b
            4'hc: seg.abcdefgh = 8'h9c;
            4'hd: seg.abcdefgh = 8'h7a;  // Lower case d
            4'he: seg.abcdefgh = 8'h9e;
            4'hf: seg.abcdefgh = 8'h8e;
        endcase
    end

    // Index stays inside the six digits
    digit_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(seg.digit));

endmodule

`default_nettype wire

// File: tb_board_top.sv
`default_nettype none

module tb_board_top;

    timeunit 1ns;
    timeprecision 1ps;

    // Small values so ticks and scans come quickly
    localparam int clk_mhz      = 1;
    localparam int tick_hz      = 1000;
    localparam int mic_sck_half = 2;
    localparam int scan_div     = 4;

    localparam int tick_cycles  = clk_mhz * 1_000_000 / tick_hz;
    localparam int frame_cycles = 128 * mic_sck_half;  // 64 sck periods

    logic        clk = 1'b0;
    logic        rst_n;
    logic [1:0]  key_n;
    logic [0:0]  sw;
    logic        mic_sd = 1'b0;
    logic [15:0] led;
    logic [7:0]  abcdefgh;
    logic [5:0]  digit_n;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;

    logic [31:0] lfsr = 32'h5058;
    logic [23:0] next_sample = '0;  // Value for the next frame
    logic [23:0] word;              // Frame being sent
    logic        sck_q;
    logic        ws_q;
    int          slot;              // sck falls since ws fell
    int          frame_cnt;
    int          cyc;               // Cycles since reset release
    int          errors;
    int          checks;
    int          test_errors;
    int          passed;
    int          failed;

    board_specific_top #(
        .clk_mhz      (clk_mhz),
        .tick_hz      (tick_hz),
        .mic_sck_half (mic_sck_half),
        .scan_div     (scan_div)
    ) dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_n    (key_n),
        .sw       (sw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit_n  (digit_n),
        .mic_sck  (mic_sck),
        .mic_ws   (mic_ws),
        .mic_lr   (mic_lr),
        .mic_sd   (mic_sd)
    );

    always #10 clk = ~clk;  // 20 ns period

    always @(posedge clk) begin
        if (!rst_n) cyc <= 0;
        else        cyc <= cyc + 1;
    end

    // ------------------------------------------------------------------------
    // Microphone model, left slot, one-bit delay, MSB first
    // ------------------------------------------------------------------------

    always @(negedge clk) begin
        if (!rst_n) begin
            sck_q     <= 1'b0;
            ws_q      <= 1'b0;
            slot      <= 64;      // Silent until first frame
            frame_cnt <= 0;
            mic_sd    <= 1'b0;
        end else begin
            sck_q <= mic_sck;
            ws_q  <= mic_ws;
            if (sck_q && !mic_sck) begin
                if (ws_q && !mic_ws) begin  // Frame start
                    slot      <= 0;
                    word      <= next_sample;
                    frame_cnt <= frame_cnt + 1;
                    mic_sd    <= 1'b0;      // Delay bit
                end else begin
                    slot <= slot + 1;
                    if (!mic_ws && slot < 24) mic_sd <= word[23 - slot];
                    else                      mic_sd <= 1'b0;  // Unused slot bits
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Random numbers and reference rules
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);  // Taps 32,22,2,1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return r;
    endfunction

    function automatic logic [23:0] rand_sample();
        logic [31:0] r;
        r = rand_bits(24);
        return r[23:0];
    endfunction

    // |v|, full-scale negative clips
    function automatic logic [23:0] magnitude(input logic [23:0] v);
        if (v == 24'h800000) return 24'h7fffff;
        if (v[23])           return (~v) + 24'd1;
        return v;
    endfunction

    function automatic logic [15:0] thermometer(input logic [23:0] m);
        logic [15:0] t;
        for (int i = 0; i < 16; i++) begin
            t[i] = ((m >> (i + 8)) != 24'd0);  // Any bit at or above 2^(i+8)
        end
        return t;
    endfunction

    function automatic logic [7:0] seg_pattern(input logic [3:0] n);
        case (n)
            4'h0: return 8'hfc;
            4'h1: return 8'h60;
            4'h2: return 8'hda;
            4'h3: return 8'hf2;
            4'h4: return 8'h66;
            4'h5: return 8'hb6;
            4'h6: return 8'hbe;
            4'h7: return 8'he0;
            4'h8: return 8'hfe;
            4'h9: return 8'hf6;
            4'ha: return 8'hee;
            4'hb: return 8'h3e;
            4'hc: return 8'h9c;
            4'hd: return 8'h7a;
            4'he: return 8'h9e;
            default: return 8'h8e;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_frames(input int n);
        int start;
        int guard;
        @(negedge clk);
        start = frame_cnt;
        for (guard = 0; guard < (n + 1) * frame_cycles; guard++) begin
            @(negedge clk);
            if (frame_cnt - start >= n) break;
        end
        if (frame_cnt - start < n) report_timeout("microphone frames");
    endtask

    task automatic wait_tick_phase(input int phase);
        int guard;
        for (guard = 0; guard < tick_cycles + 10; guard++) begin
            @(negedge clk);
            if (cyc % tick_cycles == phase) break;
        end
        if (cyc % tick_cycles != phase) report_timeout("tick phase");
    endtask

    // Two full frames of the value reach the receiver
    task automatic send_sample(input logic [23:0] v);
        next_sample <= v;
        wait_frames(3);
    endtask

    task automatic press_key(input int k);
        int hold;
        hold = 2 + int'(rand_bits(2));  // Random press length
        key_n[k] = 1'b0;
        wait_cycles(hold);
        key_n[k] = 1'b1;
        wait_cycles(8);
    endtask

    // Scan all six digits and compare each against the hex pattern
    task automatic check_digits(input logic [23:0] v);
        logic [5:0] enable_n;
        int         guard;
        for (int d = 0; d < 6; d++) begin
            enable_n = ~(6'b000001 << d);
            for (guard = 0; guard < 6 * scan_div + 4; guard++) begin
                @(negedge clk);
                if (digit_n == enable_n) break;
            end
            if (digit_n != enable_n) begin
                report_timeout($sformatf("digit %0d enable", d));
            end else begin
                check_value($sformatf("abcdefgh digit %0d", d), 32'(abcdefgh),
                            32'(seg_pattern(v[d*4 +: 4])));
            end
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_errors) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
            failed++;
        end
        test_errors = errors;
    endtask

    // ws period and sck half periods over two frames
    task automatic check_framing();
        int   guard;
        int   run_len;
        int   low_rises;
        int   high_rises;
        int   frames;
        logic sck_p;
        logic ws_p;
        logic found;
        ws_p  = mic_ws;
        found = 1'b0;
        for (guard = 0; guard < 3 * frame_cycles && !found; guard++) begin
            @(negedge clk);
            if (ws_p && !mic_ws) found = 1'b1;
            ws_p = mic_ws;
        end
        if (!found) begin
            report_timeout("ws fall");
        end else begin
            sck_p      = mic_sck;
            run_len    = 1;  // sck fell with ws
            low_rises  = 0;
            high_rises = 0;
            frames     = 0;
            for (int i = 0; i < 2 * frame_cycles; i++) begin
                @(negedge clk);
                if (mic_ws != ws_p && !(sck_p && !mic_sck)) begin
                    $display("ws changed in a cycle without a falling sck");
                    errors++;
                end
                if (mic_sck != sck_p) begin
                    check_value("sck half period", run_len, mic_sck_half);
                    run_len = 1;
                    if (mic_sck && mic_ws)  high_rises++;
                    if (mic_sck && !mic_ws) low_rises++;
                end else begin
                    run_len++;
                end
                if (ws_p && !mic_ws) begin  // Frame closed
                    check_value("ws low periods", low_rises, 32);
                    check_value("ws high periods", high_rises, 32);
                    low_rises  = 0;
                    high_rises = 0;
                    frames++;
                end
                sck_p = mic_sck;
                ws_p  = mic_ws;
            end
            check_value("ws frames", frames, 2);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        logic [23:0] s;
        logic [23:0] s2;
        logic [23:0] a;
        logic [23:0] b;
        logic [23:0] exp_max;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        passed      = 0;
        failed      = 0;
        rst_n       = 1'b0;
        key_n       = 2'b11;  // Keys released
        sw          = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Reset values
        @(negedge clk);
        check_value("mic_sck", 32'(mic_sck), 0);
        check_value("mic_ws", 32'(mic_ws), 0);
        check_value("mic_lr", 32'(mic_lr), 0);
        check_value("led", 32'(led), 0);
        check_value("digit_n", 32'(digit_n), 32'h3e);
        check_value("abcdefgh", 32'(abcdefgh), 32'(seg_pattern(4'h0)));
        end_test("reset");

        check_framing();
        end_test("i2s framing");

        for (int n = 0; n < 4; n++) begin
            s = rand_sample();
            send_sample(s);
            check_digits(s);
        end
        end_test("sample mode");

        // Two random samples inside one tick interval, silence around them
        next_sample <= '0;
        wait_frames(2);
        for (int round = 0; round < 2; round++) begin
            a = rand_sample();
            b = rand_sample();
            if (round == 0) a[23] = 1'b1;  // Negative
            else            a = 24'h800000;  // Saturating corner
            wait_cycles(60);
            wait_tick_phase(50);
            next_sample <= a;
            wait_frames(1);
            next_sample <= b;
            wait_frames(1);
            next_sample <= '0;
            wait_tick_phase(100);  // Past the closing tick
            exp_max = (magnitude(a) > magnitude(b)) ? magnitude(a) : magnitude(b);
            check_value("led", 32'(led), 32'(thermometer(exp_max)));
        end
        sw = 1'b1;  // Raw sample bits
        s  = rand_sample();
        send_sample(s);
        wait_cycles(2);
        check_value("led", 32'(led), 32'(s[23:8]));
        sw = 1'b0;
        end_test("peak and bar");

        // Hold one negative value long enough for a full interval
        s     = rand_sample();
        s[23] = 1'b1;           // Peak differs from the live value
        send_sample(s);
        wait_cycles(2 * tick_cycles + 100);
        press_key(0);
        check_digits(magnitude(s));
        press_key(0);           // Freeze
        s2 = rand_sample();
        send_sample(s2);
        wait_cycles(2 * tick_cycles + 100);  // Peak moves on to s2
        check_digits(magnitude(s));
        press_key(1);           // Back to live
        check_digits(s2);
        end_test("mode keys");

        $display("tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 passed, failed, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tick_gen.sv
`default_nettype none

module tick_gen #(
    parameter int clk_mhz = 50,  // Input clock in MHz
    parameter int tick_hz = 2    // Strobe rate
) (
    input  logic clk,
    input  logic rst_n,
    output logic slow_tick
);

    // Cycles between two strobes
    localparam int interval = clk_mhz * 1_000_000 / tick_hz;
    localparam int w_cnt    = $clog2(interval + 1);

    logic [w_cnt-1:0] cnt;  // Counts down to zero

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= w_cnt'(interval - 1);
            slow_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt       <= w_cnt'(interval - 1);  // Reload for next interval
            slow_tick <= 1'b1;
        end else begin
            cnt       <= cnt - 1'b1;
            slow_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: top.sv
`default_nettype none

module top
    import board_pkg::*;
#(
    parameter int clk_mhz      = 50,
    parameter int tick_hz      = 2,
    parameter int mic_sck_half = 8,
    parameter int scan_div     = 5000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [w_key-1:0] key,      // Active high
    input  logic [w_sw-1:0]  sw,
    output logic [w_led-1:0] led,
    output seg_drive_t       seg,
    output logic             mic_sck,
    output logic             mic_ws,
    input  logic             mic_sd
);

    mic_sample_t         sample;
    logic                slow_tick;
    logic [w_sample-1:0] peak;
    logic [w_sample-1:0] display_value;

    inmp441_mic_i2s_receiver #(.mic_sck_half(mic_sck_half)) i_microphone (
        .clk    (clk),
        .rst_n  (rst_n),
        .sck    (mic_sck),
        .ws     (mic_ws),
        .sd     (mic_sd),
        .sample (sample)
    );

    tick_gen #(.clk_mhz(clk_mhz), .tick_hz(tick_hz)) i_tick_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .slow_tick (slow_tick)
    );

    peak_meter i_peak_meter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample    (sample),
        .slow_tick (slow_tick),
        .led_raw   (sw[0]),     // Switch picks bar or raw bits
        .peak      (peak),
        .led       (led)
    );

    display_mode_fsm i_display_mode_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .key           (key),
        .sample        (sample),
        .peak          (peak),
        .display_value (display_value)
    );

    seven_seg_mux #(.scan_div(scan_div)) i_seven_seg_mux (
        .clk   (clk),
        .rst_n (rst_n),
        .value (display_value),
        .seg   (seg)
    );

endmodule

`default_nettype wire
